// ==== hw/cce_decode_pkg.sv ====
// ====================================================================
// shared widths, opcode and operand encodings and the microinstruction
// layout for the decode stage; modules pull it in by wildcard import
// ====================================================================
`default_nettype none

package cce_decode_pkg;

  // instruction geometry
  localparam int cce_inst_width_c    = 32;
  localparam int cce_op_width_c      = 3;
  localparam int cce_minor_width_c   = 4;
  localparam int cce_fields_width_c  = cce_inst_width_c - cce_op_width_c - cce_minor_width_c;
  localparam int cce_imm_width_c     = 16;
  // ALU view holds a 13 bit immediate that decode zero extends
  localparam int cce_alu_imm_width_c = 13;

  // register file and queue counts
  localparam int cce_num_gpr_c   = 4;
  localparam int cce_num_src_q_c = 5;
  localparam int cce_num_dst_q_c = 4;
  localparam int cce_num_flags_c = 12;

  typedef enum logic [cce_op_width_c-1:0] {
    e_op_alu    = 3'd0,
    e_op_branch = 3'd1,
    e_op_move   = 3'd2,
    e_op_flag   = 3'd3,
    e_op_misc   = 3'd4,
    e_op_queue  = 3'd5
  } cce_op_e;

  typedef logic [cce_minor_width_c-1:0] cce_minor_op_t;

  // minor opcodes, one set per major class
  typedef enum cce_minor_op_t {
    e_add_op = 4'd0, e_sub_op = 4'd1, e_lsh_op = 4'd2,
    e_rsh_op = 4'd3, e_and_op = 4'd4, e_or_op  = 4'd5
  } cce_alu_minor_e;

  typedef enum cce_minor_op_t {
    e_beq_op = 4'd0, e_bne_op = 4'd1, e_blt_op = 4'd2,
    e_ble_op = 4'd3, e_bi_op  = 4'd4
  } cce_branch_minor_e;

  typedef enum cce_minor_op_t {
    e_mov_op  = 4'd0,
    e_movi_op = 4'd1
  } cce_move_minor_e;

  typedef enum cce_minor_op_t {
    e_pushq_op = 4'd0,
    e_popq_op  = 4'd1,
    e_poph_op  = 4'd2,
    e_wfq_op   = 4'd3
  } cce_queue_minor_e;

  typedef enum cce_minor_op_t {
    e_stall_op = 4'd0
  } cce_misc_minor_e;

  // registers at 0..3, flag destinations at 4..15 in flag mask order
  typedef enum logic [3:0] {
    e_opd_r0   = 4'd0,  e_opd_r1  = 4'd1,  e_opd_r2   = 4'd2,  e_opd_r3 = 4'd3,
    e_opd_rqf  = 4'd4,  e_opd_nerf = 4'd5, e_opd_ldf  = 4'd6,  e_opd_nwbf = 4'd7,
    e_opd_tf   = 4'd8,  e_opd_rf  = 4'd9,  e_opd_rwbf = 4'd10, e_opd_pf = 4'd11,
    e_opd_uf   = 4'd12, e_opd_if  = 4'd13, e_opd_ef   = 4'd14, e_opd_cf = 4'd15
  } cce_opd_e;

  // flags are never sources, so the immediate source reuses the top code
  localparam cce_opd_e cce_opd_imm_c = e_opd_cf;

  // wfq mask bit i follows input queue select i
  typedef enum logic [$clog2(cce_num_src_q_c)-1:0] {
    e_src_q_lce_req       = 3'd0,
    e_src_q_lce_resp      = 3'd1,
    e_src_q_lce_data_resp = 3'd2,
    e_src_q_mem_resp      = 3'd3,
    e_src_q_mem_data_resp = 3'd4
  } cce_src_q_e;

  typedef enum logic [$clog2(cce_num_dst_q_c)-1:0] {
    e_dst_q_lce_cmd      = 2'd0,
    e_dst_q_lce_data_cmd = 2'd1,
    e_dst_q_mem_cmd      = 2'd2,
    e_dst_q_mem_data_cmd = 2'd3
  } cce_dst_q_e;

  // bit 0 is rqf, bit 11 is cf
  typedef logic [cce_num_flags_c-1:0] cce_flag_mask_t;

  // operand field views, one per opcode class
  typedef union packed {
    struct packed {
      cce_opd_e dst;
      cce_opd_e src_a;
      cce_opd_e src_b;
      logic [cce_alu_imm_width_c-1:0] imm;
    } alu;
    struct packed {
      logic                       pad;
      cce_opd_e                   src_a;
      cce_opd_e                   src_b;
      logic [cce_imm_width_c-1:0] target;
    } branch;
    struct packed {
      logic                       pad;
      cce_opd_e                   dst;
      cce_opd_e                   src;
      logic [cce_imm_width_c-1:0] imm;
    } move;
    struct packed {
      logic [19:0] pad;
      cce_opd_e    dst;
      logic        val;
    } flag;
    struct packed {
      logic [14:0]                pad;
      logic [cce_num_src_q_c-1:0] qmask;
      cce_src_q_e                 src_q;
      cce_dst_q_e                 dst_q;
    } queue;
  } cce_inst_fields_u;

  typedef struct packed {
    cce_op_e                       op;
    cce_minor_op_t                 minor_op;
    cce_inst_fields_u              fields;
  } cce_inst_s;

endpackage

`default_nettype wire

// ==== hw/cce_operand_decode.sv ====
// ====================================================================
// operand decode for ALU, branch, move and flag microinstructions;
// drives the register write mask, flag mask and branch target
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module cce_operand_decode
  import cce_decode_pkg::*;
  #(parameter int inst_addr_width_p = 8
  )
  (input  logic                          rst_n_i
   , input  cce_inst_s                   inst_i
   , input  logic                        inst_v_i

   , output logic                        decoded_v_o
   , output logic                        alu_v_o
   , output cce_opd_e                    dst_o
   , output cce_opd_e                    src_a_o
   , output cce_opd_e                    src_b_o
   , output logic [cce_imm_width_c-1:0]  imm_o
   , output logic [cce_num_gpr_c-1:0]    gpr_w_mask_o
   , output cce_flag_mask_t              flag_mask_o
   , output logic [inst_addr_width_p-1:0] pc_branch_target_o
  );

  logic       gpr_w_v;
  logic [3:0] flag_idx;

  always_comb begin
    decoded_v_o        = 1'b0;
    alu_v_o            = 1'b0;
    dst_o              = e_opd_r0;
    src_a_o            = e_opd_r0;
    src_b_o            = e_opd_r0;
    imm_o              = '0;
    flag_mask_o        = '0;
    pc_branch_target_o = '0;
    gpr_w_v            = 1'b0;
    flag_idx           = inst_i.fields.flag.dst - e_opd_rqf;

    if (rst_n_i && inst_v_i) begin
      decoded_v_o = 1'b1;

      case (inst_i.op)
        e_op_alu: begin
          gpr_w_v = 1'b1;
          alu_v_o = 1'b1;
          dst_o   = inst_i.fields.alu.dst;
          src_a_o = inst_i.fields.alu.src_a;
          src_b_o = inst_i.fields.alu.src_b;
          imm_o   = cce_imm_width_c'(inst_i.fields.alu.imm);
        end
        e_op_branch: begin
          // compare runs through the ALU
          alu_v_o            = 1'b1;
          src_a_o            = inst_i.fields.branch.src_a;
          src_b_o            = inst_i.fields.branch.src_b;
          imm_o              = inst_i.fields.branch.target;
          pc_branch_target_o = inst_i.fields.branch.target[inst_addr_width_p-1:0];
        end
        e_op_move: begin
          gpr_w_v = 1'b1;
          dst_o   = inst_i.fields.move.dst;
          if (inst_i.minor_op == e_mov_op) begin
            src_a_o = inst_i.fields.move.src;
          end
          if (inst_i.minor_op == e_movi_op) begin
            src_a_o = cce_opd_imm_c;
            imm_o   = inst_i.fields.move.imm;
          end
        end
        e_op_flag: begin
          // flag value rides in imm bit 0
          src_a_o = cce_opd_imm_c;
          imm_o   = cce_imm_width_c'(inst_i.fields.flag.val);
          dst_o   = inst_i.fields.flag.dst;
          if (inst_i.fields.flag.dst >= e_opd_rqf) begin
            flag_mask_o = cce_flag_mask_t'(1) << flag_idx;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // one-hot register write on the destination
  always_comb begin
    for (int i = 0; i < cce_num_gpr_c; i++) begin
      gpr_w_mask_o[i] = gpr_w_v && (dst_o == cce_opd_e'(i));
    end
  end

endmodule

`default_nettype wire

// ==== hw/cce_queue_decode.sv ====
// ====================================================================
// queue op decode: push valids and pop strobes for PUSHQ, POPQ and POPH,
// with the memory data response hold-off and its stall request
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module cce_queue_decode
  import cce_decode_pkg::*;
  (input  logic        rst_n_i
   , input  cce_inst_s inst_i
   , input  logic      inst_v_i

   , input  logic      lce_req_v_i
   , input  logic      lce_resp_v_i
   , input  logic      lce_data_resp_v_i
   , input  logic      mem_resp_v_i
   , input  logic      mem_data_resp_v_i
   , input  logic      lce_data_cmd_ready_i

   , output logic      lce_cmd_v_o
   , output logic      lce_data_cmd_v_o
   , output logic      mem_cmd_v_o
   , output logic      mem_data_cmd_v_o

   , output logic      lce_req_yumi_o
   , output logic      lce_resp_yumi_o
   , output logic      lce_data_resp_yumi_o
   , output logic      mem_resp_yumi_o
   , output logic      mem_data_resp_yumi_o

   , output logic      queue_stall_o
  );

  logic       pushq_op;
  logic       popq_op;
  logic       poph_op;
  logic       issue_v;
  logic       src_v;
  logic       mem_busy;
  logic       push_hold;
  logic       pop_hold;
  cce_dst_q_e push_sel;
  cce_src_q_e pop_sel;

  assign pushq_op = (inst_i.op == e_op_queue) && (inst_i.minor_op == e_pushq_op);
  assign popq_op  = (inst_i.op == e_op_queue) && (inst_i.minor_op == e_popq_op);
  assign poph_op  = (inst_i.op == e_op_queue) && (inst_i.minor_op == e_poph_op);
  assign push_sel = inst_i.fields.queue.dst_q;
  assign pop_sel  = inst_i.fields.queue.src_q;
  assign issue_v  = rst_n_i && inst_v_i;

  // valid level of the selected input queue; unused selects never wait
  always_comb begin
    case (pop_sel)
      e_src_q_lce_req:       src_v = lce_req_v_i;
      e_src_q_lce_resp:      src_v = lce_resp_v_i;
      e_src_q_lce_data_resp: src_v = lce_data_resp_v_i;
      e_src_q_mem_resp:      src_v = mem_resp_v_i;
      e_src_q_mem_data_resp: src_v = mem_data_resp_v_i;
      default:               src_v = 1'b1;
    endcase
  end

  // memory data response is being forwarded this cycle
  assign mem_busy  = mem_data_resp_v_i && lce_data_cmd_ready_i;
  assign pop_hold  = mem_busy && popq_op && (pop_sel == e_src_q_mem_resp);
  assign push_hold = mem_busy && pushq_op
                     && ((push_sel == e_dst_q_mem_cmd) || (push_sel == e_dst_q_mem_data_cmd));

  assign lce_cmd_v_o      = issue_v && pushq_op && (push_sel == e_dst_q_lce_cmd);
  assign lce_data_cmd_v_o = issue_v && pushq_op && (push_sel == e_dst_q_lce_data_cmd);
  assign mem_cmd_v_o      = issue_v && pushq_op && !push_hold && (push_sel == e_dst_q_mem_cmd);
  assign mem_data_cmd_v_o = issue_v && pushq_op && !push_hold
                            && (push_sel == e_dst_q_mem_data_cmd);

  // POPH only peeks, so strobes come from POPQ alone
  assign lce_req_yumi_o       = issue_v && popq_op && lce_req_v_i
                                && (pop_sel == e_src_q_lce_req);
  assign lce_resp_yumi_o      = issue_v && popq_op && lce_resp_v_i
                                && (pop_sel == e_src_q_lce_resp);
  assign lce_data_resp_yumi_o = issue_v && popq_op && lce_data_resp_v_i
                                && (pop_sel == e_src_q_lce_data_resp);
  assign mem_resp_yumi_o      = issue_v && popq_op && mem_resp_v_i && !pop_hold
                                && (pop_sel == e_src_q_mem_resp);
  assign mem_data_resp_yumi_o = issue_v && popq_op && mem_data_resp_v_i
                                && (pop_sel == e_src_q_mem_data_resp);

  // follows the instruction even when it is not valid
  assign queue_stall_o = rst_n_i
                         && (((popq_op || poph_op) && !src_v) || pop_hold || push_hold);

endmodule

`default_nettype wire

// ==== hw/cce_fetch_control.sv ====
// ====================================================================
// fetch stall level for the microcode PC; merges STALL, push back-pressure,
// WFQ misses and the queue decoder's stall request
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module cce_fetch_control
  import cce_decode_pkg::*;
  (input  logic        rst_n_i
   , input  cce_inst_s inst_i

   , input  logic      lce_req_v_i
   , input  logic      lce_resp_v_i
   , input  logic      lce_data_resp_v_i
   , input  logic      mem_resp_v_i
   , input  logic      mem_data_resp_v_i

   , input  logic      lce_cmd_ready_i
   , input  logic      lce_data_cmd_ready_i
   , input  logic      mem_cmd_ready_i
   , input  logic      mem_data_cmd_ready_i

   , input  logic      queue_stall_i

   , output logic      pc_stall_o
  );

  logic                       stall_op;
  logic                       wfq_op;
  logic                       pushq_op;
  logic                       dst_ready;
  logic                       wfq_hit;
  logic [cce_num_src_q_c-1:0] src_v_vec;

  assign stall_op = (inst_i.op == e_op_misc) && (inst_i.minor_op == e_stall_op);
  assign wfq_op   = (inst_i.op == e_op_queue) && (inst_i.minor_op == e_wfq_op);
  assign pushq_op = (inst_i.op == e_op_queue) && (inst_i.minor_op == e_pushq_op);

  // bit order matches the input queue select codes
  assign src_v_vec = {mem_data_resp_v_i, mem_resp_v_i, lce_data_resp_v_i,
                      lce_resp_v_i, lce_req_v_i};
  assign wfq_hit   = |(inst_i.fields.queue.qmask & src_v_vec);

  always_comb begin
    case (inst_i.fields.queue.dst_q)
      e_dst_q_lce_cmd:      dst_ready = lce_cmd_ready_i;
      e_dst_q_lce_data_cmd: dst_ready = lce_data_cmd_ready_i;
      e_dst_q_mem_cmd:      dst_ready = mem_cmd_ready_i;
      default:              dst_ready = mem_data_cmd_ready_i;
    endcase
  end

  assign pc_stall_o = rst_n_i && (stall_op || (wfq_op && !wfq_hit)
                                  || (pushq_op && !dst_ready) || queue_stall_i);

endmodule

`default_nettype wire

// ==== hw/cce_inst_decode.sv ====
// ====================================================================
// instruction decode stage of the coherence engine's microcode processor;
// purely combinational, sits between PC fetch and the execute datapath
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module cce_inst_decode
  import cce_decode_pkg::*;
  #(parameter int inst_addr_width_p = 8
  )
  (input  logic                           rst_n_i

   // microinstruction from fetch
   , input  cce_inst_s                    inst_i
   , input  logic                         inst_v_i

   // input queue valid levels
   , input  logic                         lce_req_v_i
   , input  logic                         lce_resp_v_i
   , input  logic                         lce_data_resp_v_i
   , input  logic                         mem_resp_v_i
   , input  logic                         mem_data_resp_v_i

   // output queue ready levels
   , input  logic                         lce_cmd_ready_i
   , input  logic                         lce_data_cmd_ready_i
   , input  logic                         mem_cmd_ready_i
   , input  logic                         mem_data_cmd_ready_i

   // decoded operands
   , output logic                         decoded_v_o
   , output logic                         alu_v_o
   , output cce_opd_e                     dst_o
   , output cce_opd_e                     src_a_o
   , output cce_opd_e                     src_b_o
   , output logic [cce_imm_width_c-1:0]   imm_o
   , output logic [cce_num_gpr_c-1:0]     gpr_w_mask_o
   , output cce_flag_mask_t               flag_mask_o

   // queue strobes
   , output logic                         lce_cmd_v_o
   , output logic                         lce_data_cmd_v_o
   , output logic                         mem_cmd_v_o
   , output logic                         mem_data_cmd_v_o
   , output logic                         lce_req_yumi_o
   , output logic                         lce_resp_yumi_o
   , output logic                         lce_data_resp_yumi_o
   , output logic                         mem_resp_yumi_o
   , output logic                         mem_data_resp_yumi_o

   // back to fetch
   , output logic                         pc_stall_o
   , output logic [inst_addr_width_p-1:0] pc_branch_target_o
  );

  logic queue_stall;

  cce_operand_decode
    #(.inst_addr_width_p(inst_addr_width_p))
    operand_decode_inst
     (.rst_n_i(rst_n_i), .inst_i(inst_i), .inst_v_i(inst_v_i)
      , .decoded_v_o(decoded_v_o), .alu_v_o(alu_v_o)
      , .dst_o(dst_o), .src_a_o(src_a_o), .src_b_o(src_b_o), .imm_o(imm_o)
      , .gpr_w_mask_o(gpr_w_mask_o), .flag_mask_o(flag_mask_o)
      , .pc_branch_target_o(pc_branch_target_o)
     );

  cce_queue_decode
    queue_decode_inst
     (.rst_n_i(rst_n_i), .inst_i(inst_i), .inst_v_i(inst_v_i)
      , .lce_req_v_i(lce_req_v_i), .lce_resp_v_i(lce_resp_v_i)
      , .lce_data_resp_v_i(lce_data_resp_v_i), .mem_resp_v_i(mem_resp_v_i)
      , .mem_data_resp_v_i(mem_data_resp_v_i), .lce_data_cmd_ready_i(lce_data_cmd_ready_i)
      , .lce_cmd_v_o(lce_cmd_v_o), .lce_data_cmd_v_o(lce_data_cmd_v_o)
      , .mem_cmd_v_o(mem_cmd_v_o), .mem_data_cmd_v_o(mem_data_cmd_v_o)
      , .lce_req_yumi_o(lce_req_yumi_o), .lce_resp_yumi_o(lce_resp_yumi_o)
      , .lce_data_resp_yumi_o(lce_data_resp_yumi_o), .mem_resp_yumi_o(mem_resp_yumi_o)
      , .mem_data_resp_yumi_o(mem_data_resp_yumi_o)
      , .queue_stall_o(queue_stall)
     );

  cce_fetch_control
    fetch_control_inst
     (.rst_n_i(rst_n_i), .inst_i(inst_i)
      , .lce_req_v_i(lce_req_v_i), .lce_resp_v_i(lce_resp_v_i)
      , .lce_data_resp_v_i(lce_data_resp_v_i), .mem_resp_v_i(mem_resp_v_i)
      , .mem_data_resp_v_i(mem_data_resp_v_i)
      , .lce_cmd_ready_i(lce_cmd_ready_i), .lce_data_cmd_ready_i(lce_data_cmd_ready_i)
      , .mem_cmd_ready_i(mem_cmd_ready_i), .mem_data_cmd_ready_i(mem_data_cmd_ready_i)
      , .queue_stall_i(queue_stall)
      , .pc_stall_o(pc_stall_o)
     );

endmodule

`default_nettype wire

// ==== bench/cce_decode_model.svh ====
// ====================================================================
// reference model for the decode stage testbench; builds random
// microinstructions and predicts every DUT output from the decode rules
// ====================================================================
`ifndef CCE_DECODE_MODEL_SVH
`define CCE_DECODE_MODEL_SVH

typedef struct {
  logic                       decoded_v;
  logic                       alu_v;
  cce_opd_e                   dst;
  cce_opd_e                   src_a;
  cce_opd_e                   src_b;
  logic [cce_imm_width_c-1:0] imm;
  logic [cce_num_gpr_c-1:0]   gpr_mask;
  cce_flag_mask_t             flag_mask;
  logic [cce_imm_width_c-1:0] target;
} opd_pred_s;

// random microinstruction biased toward queue ops
function automatic cce_inst_s rand_inst();
  cce_inst_s   inst;
  int unsigned pick;
  inst = cce_inst_s'($urandom);
  pick = $urandom_range(0, 9);
  case (pick)
    0: begin
      inst.op       = e_op_alu;
      inst.minor_op = cce_minor_op_t'($urandom_range(0, 5));
    end
    1: begin
      inst.op       = e_op_branch;
      inst.minor_op = cce_minor_op_t'($urandom_range(0, 4));
    end
    2: begin
      inst.op       = e_op_move;
      inst.minor_op = cce_minor_op_t'($urandom_range(0, 1));
    end
    3: begin
      inst.op                = e_op_flag;
      inst.minor_op          = '0;
      inst.fields.flag.dst   = cce_opd_e'($urandom_range(4, 15));
    end
    4: begin
      inst.op       = e_op_misc;
      inst.minor_op = e_stall_op;
    end
    default: begin
      inst.op                 = e_op_queue;
      inst.minor_op           = cce_minor_op_t'($urandom_range(0, 3));
      inst.fields.queue.src_q = cce_src_q_e'($urandom_range(0, 4));
    end
  endcase
  return inst;
endfunction

function automatic opd_pred_s predict_operands(cce_inst_s inst, logic valid, logic rst_n);
  opd_pred_s p;
  p.decoded_v = rst_n && valid;
  p.alu_v     = 1'b0;
  p.dst       = e_opd_r0;
  p.src_a     = e_opd_r0;
  p.src_b     = e_opd_r0;
  p.imm       = '0;
  p.gpr_mask  = '0;
  p.flag_mask = '0;
  p.target    = '0;
  if (p.decoded_v) begin
    case (inst.op)
      e_op_alu: begin
        p.alu_v = 1'b1;
        p.dst   = inst.fields.alu.dst;
        p.src_a = inst.fields.alu.src_a;
        p.src_b = inst.fields.alu.src_b;
        p.imm   = {3'b000, inst.fields.alu.imm};
      end
      e_op_branch: begin
        p.alu_v  = 1'b1;
        p.src_a  = inst.fields.branch.src_a;
        p.src_b  = inst.fields.branch.src_b;
        p.imm    = inst.fields.branch.target;
        p.target = inst.fields.branch.target;
      end
      e_op_move: begin
        p.dst = inst.fields.move.dst;
        if (inst.minor_op == e_movi_op) begin
          p.src_a = cce_opd_imm_c;
          p.imm   = inst.fields.move.imm;
        end else begin
          p.src_a = inst.fields.move.src;
        end
      end
      e_op_flag: begin
        p.dst    = inst.fields.flag.dst;
        p.src_a  = cce_opd_imm_c;
        p.imm[0] = inst.fields.flag.val;
        p.flag_mask[int'(inst.fields.flag.dst) - 4] = 1'b1;
      end
      default: begin
      end
    endcase
    // register write on r0..r3 for alu and move only
    if ((inst.op == e_op_alu || inst.op == e_op_move) && int'(p.dst) < 4) begin
      p.gpr_mask = 4'b0001 << int'(p.dst);
    end
  end
  return p;
endfunction

// memory data response forward blocks memory pushes and the mem_resp pop
function automatic logic mem_conflict(cce_inst_s inst, logic [4:0] q_v, logic [3:0] q_rdy);
  logic popq;
  logic pushq;
  popq  = (inst.op == e_op_queue) && (inst.minor_op == e_popq_op);
  pushq = (inst.op == e_op_queue) && (inst.minor_op == e_pushq_op);
  return q_v[4] && q_rdy[1]
         && ((popq && inst.fields.queue.src_q == e_src_q_mem_resp)
             || (pushq && (inst.fields.queue.dst_q == e_dst_q_mem_cmd
                           || inst.fields.queue.dst_q == e_dst_q_mem_data_cmd)));
endfunction

// result is {pop strobes[4:0], push valids[3:0]}
function automatic logic [8:0] predict_strobes(cce_inst_s inst, logic valid, logic rst_n,
                                               logic [4:0] q_v, logic [3:0] q_rdy);
  logic [3:0] push;
  logic [4:0] pop;
  push = '0;
  pop  = '0;
  if (rst_n && valid && inst.op == e_op_queue) begin
    if (inst.minor_op == e_pushq_op) begin
      push[inst.fields.queue.dst_q] = 1'b1;
    end
    if (inst.minor_op == e_popq_op) begin
      pop[inst.fields.queue.src_q] = q_v[inst.fields.queue.src_q];
    end
    if (mem_conflict(inst, q_v, q_rdy)) begin
      push[3:2] = 2'b00;
      pop[3]    = 1'b0;
    end
  end
  return {pop, push};
endfunction

// stall ignores inst valid and only reset masks it
function automatic logic predict_stall(cce_inst_s inst, logic rst_n,
                                       logic [4:0] q_v, logic [3:0] q_rdy);
  logic stall;
  stall = mem_conflict(inst, q_v, q_rdy);
  if (inst.op == e_op_misc && inst.minor_op == e_stall_op) begin
    stall = 1'b1;
  end
  if (inst.op == e_op_queue) begin
    case (inst.minor_op)
      e_pushq_op: stall |= !q_rdy[inst.fields.queue.dst_q];
      e_popq_op:  stall |= !q_v[inst.fields.queue.src_q];
      e_poph_op:  stall |= !q_v[inst.fields.queue.src_q];
      e_wfq_op:   stall |= ((inst.fields.queue.qmask & q_v) == '0);
      default:    stall |= 1'b0;
    endcase
  end
  return rst_n && stall;
endfunction

`endif

// ==== bench/cce_inst_decode_tb.sv ====
// ====================================================================
// random testbench for the decode stage; drives on the falling edge and
// checks every output against the reference model at the rising edge
// ====================================================================
`timescale 1ns/10ps
`default_nettype none

module cce_inst_decode_tb
  import cce_decode_pkg::*;
  ();

  localparam int          addr_width_c = 8;
  localparam int          num_iters_c  = 4000;
  localparam int          timeout_c    = 5000;
  localparam logic [31:0] seed_c       = 32'hc2abe791;

  `include "cce_decode_model.svh"

  logic                       clk;
  logic                       rst_n_i;
  cce_inst_s                  inst_i;
  logic                       inst_v_i;
  // bit i follows queue select code i
  logic [4:0]                 q_v;
  logic [3:0]                 q_rdy;

  logic                       decoded_v_o;
  logic                       alu_v_o;
  cce_opd_e                   dst_o;
  cce_opd_e                   src_a_o;
  cce_opd_e                   src_b_o;
  logic [cce_imm_width_c-1:0] imm_o;
  logic [cce_num_gpr_c-1:0]   gpr_w_mask_o;
  cce_flag_mask_t             flag_mask_o;
  logic [3:0]                 push_v;
  logic [4:0]                 yumi;
  logic                       pc_stall_o;
  logic [addr_width_c-1:0]    pc_branch_target_o;

  cce_inst_decode #(.inst_addr_width_p(addr_width_c)) cce_inst_decode_inst (
    .rst_n_i(rst_n_i), .inst_i(inst_i), .inst_v_i(inst_v_i),
    .lce_req_v_i(q_v[0]), .lce_resp_v_i(q_v[1]), .lce_data_resp_v_i(q_v[2]),
    .mem_resp_v_i(q_v[3]), .mem_data_resp_v_i(q_v[4]),
    .lce_cmd_ready_i(q_rdy[0]), .lce_data_cmd_ready_i(q_rdy[1]),
    .mem_cmd_ready_i(q_rdy[2]), .mem_data_cmd_ready_i(q_rdy[3]),
    .decoded_v_o(decoded_v_o), .alu_v_o(alu_v_o), .dst_o(dst_o),
    .src_a_o(src_a_o), .src_b_o(src_b_o), .imm_o(imm_o),
    .gpr_w_mask_o(gpr_w_mask_o), .flag_mask_o(flag_mask_o),
    .lce_cmd_v_o(push_v[0]), .lce_data_cmd_v_o(push_v[1]),
    .mem_cmd_v_o(push_v[2]), .mem_data_cmd_v_o(push_v[3]),
    .lce_req_yumi_o(yumi[0]), .lce_resp_yumi_o(yumi[1]), .lce_data_resp_yumi_o(yumi[2]),
    .mem_resp_yumi_o(yumi[3]), .mem_data_resp_yumi_o(yumi[4]),
    .pc_stall_o(pc_stall_o), .pc_branch_target_o(pc_branch_target_o)
  );

  always #4 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      $display("Test failures found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic drive_random();
    inst_i   = rand_inst();
    inst_v_i = ($urandom_range(0, 7) != 0);
    q_v      = 5'($urandom);
    q_rdy    = 4'($urandom);
  endtask

  task automatic check_outputs();
    opd_pred_s  p;
    logic [8:0] s;
    p = predict_operands(inst_i, inst_v_i, rst_n_i);
    s = predict_strobes(inst_i, inst_v_i, rst_n_i, q_v, q_rdy);
    compare_value("decoded_v_o", decoded_v_o, p.decoded_v);
    compare_value("alu_v_o", alu_v_o, p.alu_v);
    compare_value("dst_o", dst_o, p.dst);
    compare_value("src_a_o", src_a_o, p.src_a);
    compare_value("src_b_o", src_b_o, p.src_b);
    compare_value("imm_o", imm_o, p.imm);
    compare_value("gpr_w_mask_o", gpr_w_mask_o, p.gpr_mask);
    compare_value("flag_mask_o", flag_mask_o, p.flag_mask);
    compare_value("pc_branch_target_o", pc_branch_target_o, p.target[addr_width_c-1:0]);
    compare_value("push_v", push_v, s[3:0]);
    compare_value("yumi", yumi, s[8:4]);
    compare_value("pc_stall_o", pc_stall_o, predict_stall(inst_i, rst_n_i, q_v, q_rdy));
  endtask

  initial begin
    int iter;
    int cycles;
    clk      = 1'b0;
    rst_n_i  = 1'b0;
    inst_i   = '0;
    inst_v_i = 1'b0;
    q_v      = '0;
    q_rdy    = '0;
    iter     = 0;
    cycles   = 0;
    void'($urandom(seed_c));

    // reset cycles are checked as well and expect all zeros
    while (iter < num_iters_c) begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout_c) begin
        $display("Test failures found");
        $fatal(1, "timeout: the stimulus loop ran past its cycle limit");
      end
      rst_n_i = (cycles > 2);
      drive_random();
      @(posedge clk);
      check_outputs();
      if (rst_n_i) begin
        iter++;
      end
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+bench
hw/cce_decode_pkg.sv
hw/cce_operand_decode.sv
hw/cce_queue_decode.sv
hw/cce_fetch_control.sv
hw/cce_inst_decode.sv
bench/cce_inst_decode_tb.sv
